// File: verilog/ita_package.sv
// ITA shared definitions
// Tile dimensions, element widths, vector types and activation modes

`default_nettype none

package ita_package;

  localparam int unsigned N  = 4;
  localparam int unsigned M  = 4;
  localparam int unsigned WI = 8;

  localparam int unsigned BiasW = 24;
  localparam int unsigned AccW  = 32;

  typedef logic signed [WI-1:0]    elem_t;
  typedef logic signed [BiasW-1:0] bias_elem_t;
  typedef logic signed [AccW-1:0]  acc_elem_t;

  // Row m of a weight tile feeds output lane m
  typedef elem_t      [N-1:0] inp_t;
  typedef inp_t       [M-1:0] weight_t;
  typedef bias_elem_t [M-1:0] bias_t;
  typedef acc_elem_t  [M-1:0] acc_t;
  typedef elem_t      [M-1:0] oup_t;

  typedef logic        [7:0] requant_mult_t;
  typedef logic        [4:0] requant_shift_t;
  typedef logic signed [7:0] requant_add_t;
  typedef logic        [7:0] tile_cnt_t;

  typedef enum logic {
    Identity = 1'b0,
    Relu     = 1'b1
  } activation_e;

endpackage

`default_nettype wire

// File: verilog/ita_calc_if.sv
// ITA calc bundle
// Per-beat strobes and operands from the controller to the datapath

`default_nettype none

interface ita_calc_if
  import ita_package::*;
();

  logic  calc_en;
  logic  first_tile;
  logic  last_tile;
  inp_t  inp;
  bias_t bias;

  modport ctrl (
    output calc_en, first_tile, last_tile, inp, bias
  );

  modport dp (
    input calc_en, first_tile, last_tile, inp, bias
  );

endinterface

`default_nettype wire

// File: verilog/ita_controller.sv
// ITA controller
// Latches the job configuration, fires calc beats over the inner tiles
// and reserves output FIFO slots for results in flight

`default_nettype none

module ita_controller
  import ita_package::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  tile_cnt_t                          inner_tiles_i,
  input  requant_mult_t                      requant_mult_i,
  input  requant_shift_t                     requant_shift_i,
  input  requant_add_t                       requant_add_i,
  input  activation_e                        activation_i,
  input  logic                               inp_valid_i,
  output logic                               inp_ready_o,
  input  inp_t                               inp_i,
  input  logic                               inp_bias_valid_i,
  output logic                               inp_bias_ready_o,
  input  bias_t                              inp_bias_i,
  input  logic                               weight_valid_i,
  output logic                               weight_pop_o,
  input  logic                               push_i,
  input  logic [$clog2(FifoDepth + 1)-1:0]   fifo_usage_i,
  output requant_mult_t                      requant_mult_o,
  output requant_shift_t                     requant_shift_o,
  output requant_add_t                       requant_add_o,
  output activation_e                        activation_o,
  output logic                               busy_o,
  ita_calc_if.ctrl                           calc_o
);

  localparam int unsigned UsageW = $clog2(FifoDepth + 1);

  tile_cnt_t         tile_cnt_q;
  tile_cnt_t         tiles_q;
  tile_cnt_t         tiles;
  logic [UsageW-1:0] in_flight_q;
  logic              first_tile;
  logic              last_tile;
  logic              slot_free;
  logic              fire;

  // Tile count comes straight from the port until the first beat latches it
  assign first_tile = (tile_cnt_q == '0);
  assign tiles      = first_tile ? inner_tiles_i : tiles_q;
  assign last_tile  = (tile_cnt_q == tile_cnt_t'(tiles - 8'd1));

  assign slot_free = (int'(in_flight_q) + int'(fifo_usage_i)) < FifoDepth;

  assign fire = inp_valid_i && weight_valid_i &&
                (!first_tile || inp_bias_valid_i) &&
                (!last_tile || slot_free);

  assign inp_ready_o      = fire;
  assign inp_bias_ready_o = fire && first_tile;
  assign weight_pop_o     = fire;

  assign calc_o.calc_en    = fire;
  assign calc_o.first_tile = first_tile;
  assign calc_o.last_tile  = last_tile;
  assign calc_o.inp        = inp_i;
  assign calc_o.bias       = inp_bias_i;

  assign busy_o = (tile_cnt_q != '0) || (in_flight_q != '0) || (fifo_usage_i != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tile_cnt_q      <= '0;
      tiles_q         <= '0;
      requant_mult_o  <= '0;
      requant_shift_o <= '0;
      requant_add_o   <= '0;
      activation_o    <= Identity;
    end else if (fire) begin
      tile_cnt_q <= last_tile ? '0 : tile_cnt_q + 8'd1;
      if (first_tile) begin
        tiles_q         <= inner_tiles_i;
        requant_mult_o  <= requant_mult_i;
        requant_shift_o <= requant_shift_i;
        requant_add_o   <= requant_add_i;
        activation_o    <= activation_i;
      end
    end
  end

  // Results between the last beat and the FIFO push
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight_q <= '0;
    end else begin
      case ({fire && last_tile, push_i})
        2'b10:   in_flight_q <= in_flight_q + 1'b1;
        2'b01:   in_flight_q <= in_flight_q - 1'b1;
        default: in_flight_q <= in_flight_q;
      endcase
    end
  end

  a_slots_reserved : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (int'(in_flight_q) + int'(fifo_usage_i)) <= FifoDepth
  );

endmodule

`default_nettype wire

// File: verilog/ita_weight_buffer.sv
// ITA weight buffer
// Two-entry ring so the next weight tile loads while the current one is used

`default_nettype none

module ita_weight_buffer
  import ita_package::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    inp_weight_valid_i,
  output logic    inp_weight_ready_o,
  input  weight_t inp_weight_i,
  input  logic    pop_i,
  output logic    weight_valid_o,
  output weight_t weight_o
);

  weight_t    mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;

  assign inp_weight_ready_o = (count_q != 2'd2);
  assign push               = inp_weight_valid_i && inp_weight_ready_o;
  assign weight_valid_o     = (count_q != 2'd0);
  assign weight_o           = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= inp_weight_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop_i) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop_i};
    end
  end

  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> weight_valid_o
  );

endmodule

`default_nettype wire

// File: verilog/ita_dotp_accumulator.sv
// ITA dot product and accumulator
// M parallel dot products, summed over inner tiles and seeded with the bias

`default_nettype none

module ita_dotp_accumulator
  import ita_package::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  ita_calc_if.dp        calc_i,
  input  weight_t       weight_i,
  output logic          acc_valid_o,
  output acc_t          acc_o
);

  acc_t partial;
  acc_t acc_q;

  // One signed dot product per output lane
  always_comb begin
    for (int m = 0; m < M; m++) begin
      partial[m] = '0;
      for (int n = 0; n < N; n++) begin
        partial[m] = partial[m] +
                     acc_elem_t'($signed(calc_i.inp[n]) * $signed(weight_i[m][n]));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (calc_i.calc_en) begin
      for (int m = 0; m < M; m++) begin
        if (calc_i.first_tile) begin
          acc_q[m] <= acc_elem_t'(calc_i.bias[m]) + partial[m];
        end else begin
          acc_q[m] <= acc_q[m] + partial[m];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_valid_o <= 1'b0;
    end else begin
      acc_valid_o <= calc_i.calc_en && calc_i.last_tile;
    end
  end

  assign acc_o = acc_q;

endmodule

`default_nettype wire

// File: verilog/ita_requantizer.sv
// ITA requantizer
// Scales, shifts, offsets and clips the M sums to 8 bits, then applies ReLU

`default_nettype none

module ita_requantizer
  import ita_package::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           acc_valid_i,
  input  acc_t           acc_i,
  input  requant_mult_t  mult_i,
  input  requant_shift_t shift_i,
  input  requant_add_t   add_i,
  input  activation_e    activation_i,
  output logic           push_o,
  output oup_t           oup_o
);

  localparam int unsigned ProdW = AccW + 9;

  logic signed [ProdW-1:0] prod    [M];
  logic signed [ProdW-1:0] shifted [M];
  logic signed [ProdW:0]   summed  [M];
  oup_t                    result;
  oup_t                    oup_q;

  always_comb begin
    for (int m = 0; m < M; m++) begin
      // Multiplier is unsigned, so widen it with a zero sign bit
      prod[m]    = $signed(acc_i[m]) * $signed({1'b0, mult_i});
      shifted[m] = prod[m] >>> shift_i;
      summed[m]  = shifted[m] + add_i;
      if (summed[m] > 127) begin
        result[m] = 8'sd127;
      end else if (summed[m] < -128) begin
        result[m] = -8'sd128;
      end else begin
        result[m] = summed[m][WI-1:0];
      end
      if (activation_i == Relu && result[m] < 0) begin
        result[m] = '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_valid_i) begin
      oup_q <= result;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_o <= 1'b0;
    end else begin
      push_o <= acc_valid_i;
    end
  end

  assign oup_o = oup_q;

endmodule

`default_nettype wire

// File: verilog/ita_output_fifo.sv
// ITA output FIFO
// Queue of finished output vectors with a valid/ready read side

`default_nettype none

module ita_output_fifo
  import ita_package::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             push_i,
  input  oup_t                             data_i,
  input  logic                             ready_i,
  output logic                             valid_o,
  output oup_t                             data_o,
  output logic [$clog2(FifoDepth + 1)-1:0] usage_o
);

  localparam int unsigned PtrW   = $clog2(FifoDepth);
  localparam int unsigned UsageW = $clog2(FifoDepth + 1);

  oup_t              mem_q [FifoDepth];
  logic [PtrW-1:0]   wr_ptr_q;
  logic [PtrW-1:0]   rd_ptr_q;
  logic [UsageW-1:0] usage_q;
  logic              pop;

  assign valid_o = (usage_q != '0);
  assign pop     = valid_o && ready_i;
  assign data_o  = mem_q[rd_ptr_q];
  assign usage_o = usage_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      // Pointers wrap at the depth, which need not be a power of two
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      usage_q <= usage_q + UsageW'(push_i) - UsageW'(pop);
    end
  end

  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> (usage_q != UsageW'(FifoDepth))
  );

endmodule

`default_nettype wire

// File: verilog/ita.sv
// ITA top level
// Quantized matrix-vector tile engine with an output FIFO

`default_nettype none

module ita
  import ita_package::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  tile_cnt_t      inner_tiles_i,
  input  requant_mult_t  requant_mult_i,
  input  requant_shift_t requant_shift_i,
  input  requant_add_t   requant_add_i,
  input  activation_e    activation_i,
  input  logic           inp_valid_i,
  output logic           inp_ready_o,
  input  inp_t           inp_i,
  input  logic           inp_weight_valid_i,
  output logic           inp_weight_ready_o,
  input  weight_t        inp_weight_i,
  input  logic           inp_bias_valid_i,
  output logic           inp_bias_ready_o,
  input  bias_t          inp_bias_i,
  output logic           valid_o,
  input  logic           ready_i,
  output oup_t           oup_o,
  output logic           busy_o
);

  logic                             weight_valid;
  logic                             weight_pop;
  weight_t                          weight;
  logic                             acc_valid;
  acc_t                             acc;
  logic                             push;
  oup_t                             requant_oup;
  logic [$clog2(FifoDepth + 1)-1:0] fifo_usage;
  requant_mult_t                    requant_mult;
  requant_shift_t                   requant_shift;
  requant_add_t                     requant_add;
  activation_e                      activation;

  ita_calc_if calc ();

  ita_controller #(
    .FifoDepth (FifoDepth)
  ) i_controller (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .inner_tiles_i    (inner_tiles_i),
    .requant_mult_i   (requant_mult_i),
    .requant_shift_i  (requant_shift_i),
    .requant_add_i    (requant_add_i),
    .activation_i     (activation_i),
    .inp_valid_i      (inp_valid_i),
    .inp_ready_o      (inp_ready_o),
    .inp_i            (inp_i),
    .inp_bias_valid_i (inp_bias_valid_i),
    .inp_bias_ready_o (inp_bias_ready_o),
    .inp_bias_i       (inp_bias_i),
    .weight_valid_i   (weight_valid),
    .weight_pop_o     (weight_pop),
    .push_i           (push),
    .fifo_usage_i     (fifo_usage),
    .requant_mult_o   (requant_mult),
    .requant_shift_o  (requant_shift),
    .requant_add_o    (requant_add),
    .activation_o     (activation),
    .busy_o           (busy_o),
    .calc_o           (calc.ctrl)
  );

  ita_weight_buffer i_weight_buffer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .inp_weight_valid_i (inp_weight_valid_i),
    .inp_weight_ready_o (inp_weight_ready_o),
    .inp_weight_i       (inp_weight_i),
    .pop_i              (weight_pop),
    .weight_valid_o     (weight_valid),
    .weight_o           (weight)
  );

  ita_dotp_accumulator i_dotp_accumulator (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .calc_i      (calc.dp),
    .weight_i    (weight),
    .acc_valid_o (acc_valid),
    .acc_o       (acc)
  );

  ita_requantizer i_requantizer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .acc_valid_i  (acc_valid),
    .acc_i        (acc),
    .mult_i       (requant_mult),
    .shift_i      (requant_shift),
    .add_i        (requant_add),
    .activation_i (activation),
    .push_o       (push),
    .oup_o        (requant_oup)
  );

  ita_output_fifo #(
    .FifoDepth (FifoDepth)
  ) i_output_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .data_i  (requant_oup),
    .ready_i (ready_i),
    .valid_o (valid_o),
    .data_o  (oup_o),
    .usage_o (fifo_usage)
  );

endmodule

`default_nettype wire

// File: testbench/ita_checker.sv
// ITA output checker
// Compares each accepted output vector with the head of the expected queue

`default_nettype none

module ita_checker
  import ita_package::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  input  logic ready_i,
  input  oup_t oup_i,
  input  logic busy_i,
  output int   errors_o,
  output int   received_o
);

  oup_t exp_q [$];
  int   test_cnt;
  int   test_errors_base;
  int   test_received_base;

  initial begin
    errors_o           = 0;
    received_o         = 0;
    test_cnt           = 0;
    test_errors_base   = 0;
    test_received_base = 0;
  end

  task automatic add_expected(input oup_t vec);
    exp_q.push_back(vec);
  endtask

  // Valid and ready are stable here and the transfer follows at the next rising edge
  always @(negedge clk_i) begin : compare
    oup_t exp;
    if (rst_ni && valid_i && !busy_i) begin
      $display("At time %0t busy_o was low while an output vector was waiting", $time);
      errors_o++;
    end
    if (rst_ni && valid_i && ready_i) begin
      received_o++;
      if (exp_q.size() == 0) begin
        $display("At time %0t an output vector %h arrived with no result expected",
                 $time, oup_i);
        errors_o++;
      end else begin
        exp = exp_q.pop_front();
        if (oup_i !== exp) begin
          $display("ERROR time=%0t oup_o expected=%h actual=%h", $time, exp, oup_i);
          errors_o++;
        end
      end
    end
  end

  task automatic report_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d outputs, %0d errors, %s", test_cnt, name,
             received_o - test_received_base, errors_o - test_errors_base,
             (errors_o == test_errors_base) ? "ok" : "MISMATCH");
    test_received_base = received_o;
    test_errors_base   = errors_o;
  endtask

  task automatic report_totals(input int other_errors);
    $display("totals: %0d tests, %0d outputs, %0d compare errors, %0d other errors, %0d pending",
             test_cnt, received_o, errors_o, other_errors, exp_q.size());
  endtask

endmodule

`default_nettype wire

// File: testbench/tb_ita.sv
// ITA testbench
// Seeded random jobs through the DUT, expected results from a reference model

`default_nettype none

module tb_ita
  import ita_package::*;
();

  localparam int FifoDepth    = 4;
  localparam int NumJobs      = 44;
  localparam int WatchdogTime = (NumJobs * 4 * 40 + 1000) * 40;

  logic           clk_i;
  logic           rst_ni;
  tile_cnt_t      inner_tiles_i;
  requant_mult_t  requant_mult_i;
  requant_shift_t requant_shift_i;
  requant_add_t   requant_add_i;
  activation_e    activation_i;
  logic           inp_valid_i;
  logic           inp_ready_o;
  inp_t           inp_i;
  logic           inp_weight_valid_i;
  logic           inp_weight_ready_o;
  weight_t        inp_weight_i;
  logic           inp_bias_valid_i;
  logic           inp_bias_ready_o;
  bias_t          inp_bias_i;
  logic           valid_o;
  logic           ready_i;
  oup_t           oup_o;
  logic           busy_o;

  inp_t    job_inp [4];
  weight_t job_w [4];
  bias_t   job_bias;
  int      gap_max;
  bit      backpressure;
  int      stretch_left;
  int      issued;
  int      tb_errors;
  int      chk_errors;
  int      chk_received;

  ita #(
    .FifoDepth (FifoDepth)
  ) dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .inner_tiles_i      (inner_tiles_i),
    .requant_mult_i     (requant_mult_i),
    .requant_shift_i    (requant_shift_i),
    .requant_add_i      (requant_add_i),
    .activation_i       (activation_i),
    .inp_valid_i        (inp_valid_i),
    .inp_ready_o        (inp_ready_o),
    .inp_i              (inp_i),
    .inp_weight_valid_i (inp_weight_valid_i),
    .inp_weight_ready_o (inp_weight_ready_o),
    .inp_weight_i       (inp_weight_i),
    .inp_bias_valid_i   (inp_bias_valid_i),
    .inp_bias_ready_o   (inp_bias_ready_o),
    .inp_bias_i         (inp_bias_i),
    .valid_o            (valid_o),
    .ready_i            (ready_i),
    .oup_o              (oup_o),
    .busy_o             (busy_o)
  );

  ita_checker u_checker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (valid_o),
    .ready_i    (ready_i),
    .oup_i      (oup_o),
    .busy_i     (busy_o),
    .errors_o   (chk_errors),
    .received_o (chk_received)
  );

  always #20 clk_i = ~clk_i;

  // Ready is mostly high, with long low stretches under back-pressure
  always @(posedge clk_i) begin
    #5;
    if (stretch_left > 0) begin
      stretch_left--;
    end else if (backpressure) begin
      if (ready_i) begin
        ready_i      = 1'b0;
        stretch_left = $urandom_range(40, 15);
      end else begin
        ready_i      = 1'b1;
        stretch_left = $urandom_range(2, 0);
      end
    end else begin
      ready_i = ($urandom_range(3, 0) != 0);
    end
  end

  initial begin
    #(WatchdogTime);
    $display("Watchdog expired before all jobs finished");
    $display("Simulation FAILED");
    $finish;
  end

  function automatic elem_t requant_lane(input longint sum, input requant_mult_t mult,
                                         input requant_shift_t shift,
                                         input requant_add_t add, input activation_e act);
    longint v;
    v = sum * longint'(mult);
    v = v >>> shift;
    v = v + longint'(add);
    if (v > 127) begin
      v = 127;
    end else if (v < -128) begin
      v = -128;
    end
    if (act == Relu && v < 0) begin
      v = 0;
    end
    return elem_t'(v);
  endfunction

  // Each sender samples ready at the falling edge, where it is stable
  task automatic send_inputs(input int tiles);
    int t;
    bit taken;
    for (t = 0; t < tiles; t++) begin
      repeat ($urandom_range(gap_max, 0)) begin
        @(posedge clk_i);
        #5;
      end
      inp_valid_i = 1'b1;
      inp_i       = job_inp[t];
      taken       = 1'b0;
      while (!taken) begin
        @(negedge clk_i);
        taken = inp_ready_o;
        @(posedge clk_i);
        #5;
      end
      inp_valid_i = 1'b0;
    end
  endtask

  task automatic send_weights(input int tiles);
    int t;
    bit taken;
    for (t = 0; t < tiles; t++) begin
      repeat ($urandom_range(gap_max, 0)) begin
        @(posedge clk_i);
        #5;
      end
      inp_weight_valid_i = 1'b1;
      inp_weight_i       = job_w[t];
      taken              = 1'b0;
      while (!taken) begin
        @(negedge clk_i);
        taken = inp_weight_ready_o;
        @(posedge clk_i);
        #5;
      end
      inp_weight_valid_i = 1'b0;
    end
  endtask

  task automatic send_bias();
    bit taken;
    repeat ($urandom_range(gap_max, 0)) begin
      @(posedge clk_i);
      #5;
    end
    inp_bias_valid_i = 1'b1;
    inp_bias_i       = job_bias;
    taken            = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = inp_bias_ready_o;
      @(posedge clk_i);
      #5;
    end
    inp_bias_valid_i = 1'b0;
  endtask

  task automatic run_job(input int tiles, input bit wide, input int act_mode);
    requant_mult_t  mult;
    requant_shift_t shift;
    requant_add_t   add;
    activation_e    act;
    longint         sum;
    oup_t           exp;
    int             t;
    int             m;
    int             n;
    mult  = requant_mult_t'($urandom);
    shift = requant_shift_t'($urandom_range(12, 0));
    add   = requant_add_t'($urandom);
    case (act_mode)
      0:       act = Identity;
      1:       act = Relu;
      default: act = activation_e'($urandom_range(1, 0));
    endcase
    for (m = 0; m < M; m++) begin
      if (wide) begin
        job_bias[m] = bias_elem_t'($urandom);
      end else begin
        job_bias[m] = bias_elem_t'(int'($urandom_range(4095, 0)) - 2048);
      end
    end
    for (t = 0; t < tiles; t++) begin
      for (n = 0; n < N; n++) begin
        job_inp[t][n] = elem_t'($urandom);
      end
      for (m = 0; m < M; m++) begin
        for (n = 0; n < N; n++) begin
          job_w[t][m][n] = elem_t'($urandom);
        end
      end
    end
    // Bias once, then the dot products of every inner tile
    for (m = 0; m < M; m++) begin
      sum = longint'($signed(job_bias[m]));
      for (t = 0; t < tiles; t++) begin
        for (n = 0; n < N; n++) begin
          sum += longint'($signed(job_inp[t][n])) * longint'($signed(job_w[t][m][n]));
        end
      end
      exp[m] = requant_lane(sum, mult, shift, add, act);
    end
    u_checker.add_expected(exp);
    issued++;
    inner_tiles_i   = tile_cnt_t'(tiles);
    requant_mult_i  = mult;
    requant_shift_i = shift;
    requant_add_i   = add;
    activation_i    = act;
    fork
      send_inputs(tiles);
      send_weights(tiles);
      send_bias();
    join
  endtask

  task automatic run_test(input string name, input int jobs, input int max_tiles,
                          input bit wide, input int act_mode);
    int j;
    for (j = 0; j < jobs; j++) begin
      run_job($urandom_range(max_tiles, 1), wide, act_mode);
    end
    while (chk_received < issued) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #5;
    u_checker.report_test(name);
  endtask

  task automatic check_idle();
    int cyc;
    cyc = 0;
    while (busy_o && cyc < 20) begin
      @(negedge clk_i);
      cyc++;
    end
    if (busy_o) begin
      $display("busy_o stayed high after the last output was taken");
      tb_errors++;
    end
    repeat (10) begin
      @(negedge clk_i);
      if (valid_o) begin
        $display("valid_o went high at time %0t with no job pending", $time);
        tb_errors++;
      end
    end
  endtask

  initial begin
    void'($urandom(43138));
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    inner_tiles_i      = '0;
    requant_mult_i     = '0;
    requant_shift_i    = '0;
    requant_add_i      = '0;
    activation_i       = Identity;
    inp_valid_i        = 1'b0;
    inp_i              = '0;
    inp_weight_valid_i = 1'b0;
    inp_weight_i       = '0;
    inp_bias_valid_i   = 1'b0;
    inp_bias_i         = '0;
    ready_i            = 1'b0;
    backpressure       = 1'b0;
    stretch_left       = 0;
    gap_max            = 3;
    issued             = 0;
    tb_errors          = 0;
    repeat (8) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (valid_o || inp_ready_o || inp_bias_ready_o || busy_o || !inp_weight_ready_o) begin
      $display("Status outputs after reset do not match the idle state");
      tb_errors++;
    end
    @(posedge clk_i);
    #5;
    run_test("single_tile_identity", 8, 1, 1'b1, 0);
    run_test("multi_tile_accumulate", 8, 4, 1'b0, 0);
    run_test("relu_activation", 8, 4, 1'b0, 1);
    backpressure = 1'b1;
    run_test("output_backpressure", 10, 4, 1'b0, 2);
    backpressure = 1'b0;
    gap_max      = 6;
    run_test("valid_gaps", 10, 4, 1'b0, 2);
    check_idle();
    if (chk_received != NumJobs) begin
      $display("Received %0d output vectors for %0d jobs", chk_received, NumJobs);
      tb_errors++;
    end
    u_checker.report_totals(tb_errors);
    if (tb_errors == 0 && chk_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ita.f
verilog/ita_package.sv
verilog/ita_calc_if.sv
verilog/ita_controller.sv
verilog/ita_weight_buffer.sv
verilog/ita_dotp_accumulator.sv
verilog/ita_requantizer.sv
verilog/ita_output_fifo.sv
verilog/ita.sv
testbench/ita_checker.sv
testbench/tb_ita.sv
